// ==== project.f ====
+incdir+verification
source/controlPkg.sv
source/instructionDecoder.sv
source/controlSequencer.sv
source/datapathSignalGen.sv
source/controlUnit.sv
verification/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the controlUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/10ps \
    --top-module controlUnitTb -f project.f -o controlUnitSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/controlUnitSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^>>> PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== source/controlPkg.sv ====
package controlPkg;

    // instruction field widths and codes
    localparam int fieldWidth = 6;

    localparam logic [fieldWidth-1:0] opcodeRType = 6'd0;
    localparam logic [fieldWidth-1:0] opcodeAddi  = 6'd8;

    localparam logic [fieldWidth-1:0] functAdd  = 6'b100000;
    localparam logic [fieldWidth-1:0] functSub  = 6'b100010;
    localparam logic [fieldWidth-1:0] functAnd  = 6'b100100;
    localparam logic [fieldWidth-1:0] functSll  = 6'b000000;
    localparam logic [fieldWidth-1:0] functSrl  = 6'b000010;
    localparam logic [fieldWidth-1:0] functSra  = 6'b000011;
    localparam logic [fieldWidth-1:0] functSllv = 6'b000100;
    localparam logic [fieldWidth-1:0] functSrav = 6'b000111;
    localparam logic [fieldWidth-1:0] functJr   = 6'b001000;

    // sequencing
    localparam int stepWidth   = 2;
    localparam int fetchSteps  = 3;
    localparam int decodeSteps = 2;

    typedef enum logic [2:0] {
        stReset,
        stFetch,
        stDecode,
        stExecute,
        stOverflow
    } ctrlState_t;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opSll,
        opSrl,
        opSra,
        opSllv,
        opSrav,
        opJr,
        opAddi,
        opUnknown
    } opClass_t;

    // datapath select codes
    typedef enum logic [2:0] {
        aluPass = 3'd0,
        aluAdd  = 3'd1,
        aluSub  = 3'd2,
        aluAnd  = 3'd3
    } aluOp_t;

    typedef enum logic [2:0] {
        shiftNone       = 3'd0,
        shiftLoad       = 3'd1,
        shiftLeft       = 3'd2,
        shiftRightLogic = 3'd3,
        shiftRightArith = 3'd4
    } shiftOp_t;

    typedef enum logic [2:0] {
        destRt       = 3'd0,
        destRd       = 3'd1,
        destStackPtr = 3'd2
    } regDest_t;

    typedef enum logic [3:0] {
        dataAluOut    = 4'd0,
        dataShifter   = 4'd7,
        dataStackInit = 4'd8
    } regData_t;

    typedef enum logic [1:0] {
        srcAPc   = 2'd0,
        srcARegA = 2'd1
    } aluSrcA_t;

    typedef enum logic [1:0] {
        srcBRegB      = 2'd0,
        srcBFour      = 2'd1,
        srcBImmediate = 2'd2,
        srcBOffset    = 2'd3
    } aluSrcB_t;

    // classes that can overflow
    function automatic logic isAluClass(opClass_t opc);
        return opc inside {opAdd, opSub, opAnd, opAddi};
    endfunction

    function automatic logic isShiftClass(opClass_t opc);
        return opc inside {opSll, opSrl, opSra, opSllv, opSrav};
    endfunction

endpackage

// ==== source/controlSequencer.sv ====
`timescale 1ns/10ps

module controlSequencer (
    input  logic                             clk,
    input  logic                             reset,
    input  controlPkg::opClass_t             opClass,
    input  logic [controlPkg::stepWidth-1:0] execLast,
    input  logic                             overflow,
    output controlPkg::ctrlState_t           state,
    output logic [controlPkg::stepWidth-1:0] step,
    output logic                             retire,
    output logic                             resetOut
);
    import controlPkg::*;

    logic fetchDone;
    logic decodeDone;
    logic execDone;
    logic trapTaken;

    assign fetchDone  = (state == stFetch) && (step == stepWidth'(fetchSteps - 1));
    assign decodeDone = (state == stDecode) && (step == stepWidth'(decodeSteps - 1));
    assign execDone   = (state == stExecute) && (step == execLast);

    // overflow only matters at the write-back step of an ALU class
    assign trapTaken = execDone && isAluClass(opClass) && overflow;

    // write-back goes ahead unless the trap cancels it
    assign retire = execDone && !trapTaken &&
                    (isAluClass(opClass) || isShiftClass(opClass));

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= stReset;
            step     <= '0;
            resetOut <= 1'b1;
        end else begin
            resetOut <= 1'b0;
            case (state)
                stReset: begin
                    state <= stFetch;
                    step  <= '0;
                end

                stFetch: begin
                    if (fetchDone) begin
                        state <= stDecode;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end

                stDecode: begin
                    if (decodeDone) begin
                        state <= stExecute;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end

                stExecute: begin
                    if (execDone) begin
                        // trap replaces the return to fetch
                        state <= trapTaken ? stOverflow : stFetch;
                        step  <= '0;
                    end else begin
                        step <= step + 1'b1;
                    end
                end

                stOverflow: begin
                    // single epc cycle
                    state <= stFetch;
                    step  <= '0;
                end

                default: begin
                    state <= stFetch;
                    step  <= '0;
                end
            endcase
        end
    end

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [controlPkg::fieldWidth-1:0] opcode,
    input  logic [controlPkg::fieldWidth-1:0] funct,
    input  logic                              overflow,
    output logic                              regWrite,
    output controlPkg::regDest_t              srcWrite,
    output controlPkg::regData_t              srcData,
    output controlPkg::aluSrcA_t              aluSrcA,
    output controlPkg::aluSrcB_t              aluSrcB,
    output controlPkg::aluOp_t                aluControl,
    output logic                              aluOutControl,
    output logic                              shiftSrc,
    output logic                              shiftAmt,
    output controlPkg::shiftOp_t              shiftControl,
    output logic                              pcWrite,
    output logic                              irWrite,
    output logic                              seControl,
    output logic                              aLoad,
    output logic                              bLoad,
    output logic                              epcControl,
    output logic                              resetOut
);
    import controlPkg::*;

    opClass_t               opClass;
    logic [stepWidth-1:0]   execLast;
    ctrlState_t             state;
    logic [stepWidth-1:0]   step;
    logic                   retire;

    instructionDecoder decoder (
        .opcode   (opcode),
        .funct    (funct),
        .opClass  (opClass),
        .execLast (execLast)
    );

    controlSequencer sequencer (
        .clk      (clk),
        .reset    (reset),
        .opClass  (opClass),
        .execLast (execLast),
        .overflow (overflow),
        .state    (state),
        .step     (step),
        .retire   (retire),
        .resetOut (resetOut)
    );

    datapathSignalGen signalGen (
        .clk           (clk),
        .reset         (reset),
        .state         (state),
        .step          (step),
        .opClass       (opClass),
        .retire        (retire),
        .regWrite      (regWrite),
        .srcWrite      (srcWrite),
        .srcData       (srcData),
        .aluSrcA       (aluSrcA),
        .aluSrcB       (aluSrcB),
        .aluControl    (aluControl),
        .aluOutControl (aluOutControl),
        .shiftSrc      (shiftSrc),
        .shiftAmt      (shiftAmt),
        .shiftControl  (shiftControl),
        .pcWrite       (pcWrite),
        .irWrite       (irWrite),
        .seControl     (seControl),
        .aLoad         (aLoad),
        .bLoad         (bLoad),
        .epcControl    (epcControl)
    );

endmodule

// ==== source/datapathSignalGen.sv ====
`timescale 1ns/10ps

module datapathSignalGen (
    input  logic                             clk,
    input  logic                             reset,
    input  controlPkg::ctrlState_t           state,
    input  logic [controlPkg::stepWidth-1:0] step,
    input  controlPkg::opClass_t             opClass,
    input  logic                             retire,
    output logic                             regWrite,
    output controlPkg::regDest_t             srcWrite,
    output controlPkg::regData_t             srcData,
    output controlPkg::aluSrcA_t             aluSrcA,
    output controlPkg::aluSrcB_t             aluSrcB,
    output controlPkg::aluOp_t               aluControl,
    output logic                             aluOutControl,
    output logic                             shiftSrc,
    output logic                             shiftAmt,
    output controlPkg::shiftOp_t             shiftControl,
    output logic                             pcWrite,
    output logic                             irWrite,
    output logic                             seControl,
    output logic                             aLoad,
    output logic                             bLoad,
    output logic                             epcControl
);
    import controlPkg::*;

    logic     nxtRegWrite;
    regDest_t nxtSrcWrite;
    regData_t nxtSrcData;
    aluSrcA_t nxtAluSrcA;
    aluSrcB_t nxtAluSrcB;
    aluOp_t   nxtAluControl;
    logic     nxtAluOutControl;
    logic     nxtShiftSrc;
    logic     nxtShiftAmt;
    shiftOp_t nxtShiftControl;
    logic     nxtPcWrite;
    logic     nxtIrWrite;
    logic     nxtSeControl;
    logic     nxtALoad;
    logic     nxtBLoad;
    logic     nxtEpcControl;
    aluOp_t   classAluOp;
    shiftOp_t classShiftOp;

    assign classAluOp = (opClass == opSub) ? aluSub :
                        (opClass == opAnd) ? aluAnd : aluAdd;

    assign classShiftOp = (opClass inside {opSll, opSllv}) ? shiftLeft :
                          (opClass == opSrl)               ? shiftRightLogic :
                                                             shiftRightArith;

    // microcode table for the current state and step
    always_comb begin
        nxtRegWrite      = 1'b0;
        nxtSrcWrite      = destRt;
        nxtSrcData       = dataAluOut;
        nxtAluSrcA       = srcAPc;
        nxtAluSrcB       = srcBRegB;
        nxtAluControl    = aluPass;
        nxtAluOutControl = 1'b0;
        nxtShiftSrc      = 1'b0;
        nxtShiftAmt      = 1'b0;
        nxtShiftControl  = shiftNone;
        nxtPcWrite       = 1'b0;
        nxtIrWrite       = 1'b0;
        nxtSeControl     = 1'b0;
        nxtALoad         = 1'b0;
        nxtBLoad         = 1'b0;
        nxtEpcControl    = 1'b0;

        case (state)
            stFetch: begin
                // pc + 4 on every fetch step
                nxtAluControl = aluAdd;
                nxtAluSrcB    = srcBFour;
                if (step == stepWidth'(fetchSteps - 1)) begin
                    nxtPcWrite = 1'b1;
                    nxtIrWrite = 1'b1;
                end
            end

            stDecode: begin
                // operand fetch and branch target precompute
                nxtALoad         = 1'b1;
                nxtBLoad         = 1'b1;
                nxtSeControl     = 1'b1;
                nxtAluOutControl = 1'b1;
                nxtAluControl    = aluAdd;
                nxtAluSrcA       = srcAPc;
                nxtAluSrcB       = srcBOffset;
            end

            stExecute: begin
                if (isAluClass(opClass)) begin
                    nxtAluSrcA = srcARegA;
                    nxtAluSrcB = (opClass == opAddi) ? srcBImmediate : srcBRegB;
                    if (step == '0) begin
                        nxtAluControl    = classAluOp;
                        nxtAluOutControl = 1'b1;
                    end else if (retire) begin
                        nxtRegWrite = 1'b1;
                        nxtSrcWrite = (opClass == opAddi) ? destRt : destRd;
                        nxtSrcData  = dataAluOut;
                    end
                end else if (isShiftClass(opClass)) begin
                    // shamt field only for the immediate shifts
                    nxtShiftSrc = opClass inside {opSll, opSrl, opSra};
                    nxtShiftAmt = opClass inside {opSll, opSrl, opSra};
                    case (step)
                        2'd0, 2'd1: nxtShiftControl = shiftLoad;
                        2'd2:       nxtShiftControl = classShiftOp;
                        default: begin
                            nxtRegWrite = retire;
                            nxtSrcWrite = destRd;
                            nxtSrcData  = dataShifter;
                        end
                    endcase
                end else if (opClass == opJr) begin
                    nxtPcWrite    = 1'b1;
                    nxtAluSrcA    = srcARegA;
                    nxtAluControl = aluPass;
                end
            end

            stOverflow: begin
                nxtEpcControl = 1'b1;
            end

            default: begin
                // reset state stays idle
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // stack pointer init while reset is held
            regWrite      <= 1'b1;
            srcWrite      <= destStackPtr;
            srcData       <= dataStackInit;
            aluSrcA       <= srcAPc;
            aluSrcB       <= srcBRegB;
            aluControl    <= aluPass;
            aluOutControl <= 1'b0;
            shiftSrc      <= 1'b0;
            shiftAmt      <= 1'b0;
            shiftControl  <= shiftNone;
            pcWrite       <= 1'b0;
            irWrite       <= 1'b0;
            seControl     <= 1'b0;
            aLoad         <= 1'b0;
            bLoad         <= 1'b0;
            epcControl    <= 1'b0;
        end else begin
            regWrite      <= nxtRegWrite;
            srcWrite      <= nxtSrcWrite;
            srcData       <= nxtSrcData;
            aluSrcA       <= nxtAluSrcA;
            aluSrcB       <= nxtAluSrcB;
            aluControl    <= nxtAluControl;
            aluOutControl <= nxtAluOutControl;
            shiftSrc      <= nxtShiftSrc;
            shiftAmt      <= nxtShiftAmt;
            shiftControl  <= nxtShiftControl;
            pcWrite       <= nxtPcWrite;
            irWrite       <= nxtIrWrite;
            seControl     <= nxtSeControl;
            aLoad         <= nxtALoad;
            bLoad         <= nxtBLoad;
            epcControl    <= nxtEpcControl;
        end
    end

endmodule

// ==== source/instructionDecoder.sv ====
`timescale 1ns/10ps

module instructionDecoder (
    input  logic [controlPkg::fieldWidth-1:0] opcode,
    input  logic [controlPkg::fieldWidth-1:0] funct,
    output controlPkg::opClass_t              opClass,
    output logic [controlPkg::stepWidth-1:0]  execLast
);
    import controlPkg::*;

    // class from funct for R-type, from opcode otherwise
    always_comb begin
        opClass = opUnknown;
        if (opcode == opcodeRType) begin
            case (funct)
                functAdd:  opClass = opAdd;
                functSub:  opClass = opSub;
                functAnd:  opClass = opAnd;
                functSll:  opClass = opSll;
                functSrl:  opClass = opSrl;
                functSra:  opClass = opSra;
                functSllv: opClass = opSllv;
                functSrav: opClass = opSrav;
                functJr:   opClass = opJr;
                default:   opClass = opUnknown;
            endcase
        end else if (opcode == opcodeAddi) begin
            opClass = opAddi;
        end
    end

    // index of the last execute step for each class
    always_comb begin
        case (opClass)
            opAdd,
            opSub,
            opAnd,
            opAddi: begin
                // compute, then write back
                execLast = 2'd1;
            end
            opSll,
            opSrl,
            opSra,
            opSllv,
            opSrav: begin
                // two loads, shift, write back
                execLast = 2'd3;
            end
            default: begin
                // jr and unknown codes
                execLast = 2'd0;
            end
        endcase
    end

endmodule

// ==== verification/controlModel.svh ====
// class of the instruction currently on opcode and funct
opClass_t   curClass = opAdd;

// model of the control state before the next edge
ctrlState_t mState = stReset;
int         mStep  = 0;

logic     expRegWrite;
logic     expAluOutControl;
logic     expShiftSrc;
logic     expShiftAmt;
logic     expPcWrite;
logic     expIrWrite;
logic     expSeControl;
logic     expALoad;
logic     expBLoad;
logic     expEpcControl;
logic     expResetOut;
regDest_t expSrcWrite;
regData_t expSrcData;
aluSrcA_t expAluSrcA;
aluSrcB_t expAluSrcB;
aluOp_t   expAluControl;
shiftOp_t expShiftControl;

function automatic int executeLength(opClass_t cls);
    case (cls)
        opAdd, opSub, opAnd, opAddi: return 2;
        opSll, opSrl, opSra, opSllv, opSrav: return 4;
        default: return 1;
    endcase
endfunction

function automatic logic canOverflow(opClass_t cls);
    return cls == opAdd || cls == opSub || cls == opAnd || cls == opAddi;
endfunction

task automatic executeOutputs();
    if (canOverflow(curClass)) begin
        expAluSrcA = srcARegA;
        expAluSrcB = (curClass == opAddi) ? srcBImmediate : srcBRegB;
        if (mStep == 0) begin
            expAluControl = (curClass == opSub) ? aluSub :
                            (curClass == opAnd) ? aluAnd : aluAdd;
            expAluOutControl = 1'b1;
        end else if (!overflow) begin
            expRegWrite = 1'b1;
            expSrcWrite = (curClass == opAddi) ? destRt : destRd;
        end
    end else if (executeLength(curClass) == 4) begin
        // shamt field only for the immediate forms
        expShiftSrc = curClass inside {opSll, opSrl, opSra};
        expShiftAmt = expShiftSrc;
        if (mStep < 2) begin
            expShiftControl = shiftLoad;
        end else if (mStep == 2) begin
            case (curClass)
                opSll, opSllv: expShiftControl = shiftLeft;
                opSrl:         expShiftControl = shiftRightLogic;
                default:       expShiftControl = shiftRightArith;
            endcase
        end else begin
            expRegWrite = 1'b1;
            expSrcWrite = destRd;
            expSrcData  = dataShifter;
        end
    end else if (curClass == opJr) begin
        expPcWrite = 1'b1;
        expAluSrcA = srcARegA;
    end
endtask

// outputs expected right after the coming edge
task automatic expectOutputs();
    expRegWrite      = 1'b0;
    expSrcWrite      = destRt;
    expSrcData       = dataAluOut;
    expAluSrcA       = srcAPc;
    expAluSrcB       = srcBRegB;
    expAluControl    = aluPass;
    expAluOutControl = 1'b0;
    expShiftSrc      = 1'b0;
    expShiftAmt      = 1'b0;
    expShiftControl  = shiftNone;
    expPcWrite       = 1'b0;
    expIrWrite       = 1'b0;
    expSeControl     = 1'b0;
    expALoad         = 1'b0;
    expBLoad         = 1'b0;
    expEpcControl    = 1'b0;
    expResetOut      = reset;
    if (reset) begin
        expRegWrite = 1'b1;
        expSrcWrite = destStackPtr;
        expSrcData  = dataStackInit;
    end else begin
        case (mState)
            stFetch: begin
                expAluControl = aluAdd;
                expAluSrcB    = srcBFour;
                expPcWrite    = (mStep == fetchSteps - 1);
                expIrWrite    = (mStep == fetchSteps - 1);
            end
            stDecode: begin
                expALoad         = 1'b1;
                expBLoad         = 1'b1;
                expSeControl     = 1'b1;
                expAluOutControl = 1'b1;
                expAluControl    = aluAdd;
                expAluSrcB       = srcBOffset;
            end
            stExecute: executeOutputs();
            stOverflow: expEpcControl = 1'b1;
            default: ;
        endcase
    end
endtask

task automatic stepModel();
    if (reset) begin
        mState = stReset;
        mStep  = 0;
    end else begin
        case (mState)
            stFetch: begin
                if (mStep == fetchSteps - 1) begin
                    mState = stDecode;
                    mStep  = 0;
                end else begin
                    mStep++;
                end
            end
            stDecode: begin
                if (mStep == decodeSteps - 1) begin
                    mState = stExecute;
                    mStep  = 0;
                end else begin
                    mStep++;
                end
            end
            stExecute: begin
                if (mStep == executeLength(curClass) - 1) begin
                    mState = (canOverflow(curClass) && overflow) ? stOverflow : stFetch;
                    mStep  = 0;
                end else begin
                    mStep++;
                end
            end
            default: begin
                // reset and overflow both go on to fetch
                mState = stFetch;
                mStep  = 0;
            end
        endcase
    end
endtask

// ==== verification/controlUnitTb.sv ====
`timescale 1ns/10ps

module controlUnitTb;
    import controlPkg::*;

    logic                  clk;
    logic                  reset;
    logic [fieldWidth-1:0] opcode;
    logic [fieldWidth-1:0] funct;
    logic                  overflow;
    logic                  regWrite;
    regDest_t              srcWrite;
    regData_t              srcData;
    aluSrcA_t              aluSrcA;
    aluSrcB_t              aluSrcB;
    aluOp_t                aluControl;
    logic                  aluOutControl;
    logic                  shiftSrc;
    logic                  shiftAmt;
    shiftOp_t              shiftControl;
    logic                  pcWrite;
    logic                  irWrite;
    logic                  seControl;
    logic                  aLoad;
    logic                  bLoad;
    logic                  epcControl;
    logic                  resetOut;

    logic [31:0] lcgState = 32'hd84e_7b18;
    string       testName = "reset";
    opClass_t    directedList [0:10] = '{opAdd, opSub, opAnd, opAddi, opSll, opSrl,
                                         opSra, opSllv, opSrav, opJr, opUnknown};

    `include "controlModel.svh"

    controlUnit dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    task automatic failRun(string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareBit(string sig, logic exp, logic act);
        if (act !== exp)
            failRun($sformatf("Mismatch %s %s: expected %b, actual %b", testName, sig, exp, act));
    endtask

    task automatic compareAluOp(string sig, aluOp_t exp, aluOp_t act);
        if (act !== exp)
            failRun($sformatf("Mismatch %s %s: expected %0d, actual %0d", testName, sig, exp, act));
    endtask

    task automatic compareShiftOp(string sig, shiftOp_t exp, shiftOp_t act);
        if (act !== exp)
            failRun($sformatf("Mismatch %s %s: expected %0d, actual %0d", testName, sig, exp, act));
    endtask

    task automatic compareRegDest(string sig, regDest_t exp, regDest_t act);
        if (act !== exp)
            failRun($sformatf("Mismatch %s %s: expected %0d, actual %0d", testName, sig, exp, act));
    endtask

    task automatic compareRegData(string sig, regData_t exp, regData_t act);
        if (act !== exp)
            failRun($sformatf("Mismatch %s %s: expected %0d, actual %0d", testName, sig, exp, act));
    endtask

    task automatic compareAluSrcA(string sig, aluSrcA_t exp, aluSrcA_t act);
        if (act !== exp)
            failRun($sformatf("Mismatch %s %s: expected %0d, actual %0d", testName, sig, exp, act));
    endtask

    task automatic compareAluSrcB(string sig, aluSrcB_t exp, aluSrcB_t act);
        if (act !== exp)
            failRun($sformatf("Mismatch %s %s: expected %0d, actual %0d", testName, sig, exp, act));
    endtask

    task automatic checkOutputs();
        compareBit("regWrite", expRegWrite, regWrite);
        compareRegDest("srcWrite", expSrcWrite, srcWrite);
        compareRegData("srcData", expSrcData, srcData);
        compareAluSrcA("aluSrcA", expAluSrcA, aluSrcA);
        compareAluSrcB("aluSrcB", expAluSrcB, aluSrcB);
        compareAluOp("aluControl", expAluControl, aluControl);
        compareBit("aluOutControl", expAluOutControl, aluOutControl);
        compareBit("shiftSrc", expShiftSrc, shiftSrc);
        compareBit("shiftAmt", expShiftAmt, shiftAmt);
        compareShiftOp("shiftControl", expShiftControl, shiftControl);
        compareBit("pcWrite", expPcWrite, pcWrite);
        compareBit("irWrite", expIrWrite, irWrite);
        compareBit("seControl", expSeControl, seControl);
        compareBit("aLoad", expALoad, aLoad);
        compareBit("bLoad", expBLoad, bLoad);
        compareBit("epcControl", expEpcControl, epcControl);
        compareBit("resetOut", expResetOut, resetOut);
    endtask

    // predict the outputs, check them just after the edge and return to the drive point
    task automatic runCycle();
        expectOutputs();
        @(posedge clk);
        #1;
        checkOutputs();
        stepModel();
        #1;
    endtask

    task automatic waitForFetch();
        int cycles;
        cycles = 0;
        runCycle();
        while (irWrite !== 1'b1) begin
            cycles++;
            if (cycles >= 20)
                failRun("timeout: irWrite never came within 20 cycles");
            else
                runCycle();
        end
    endtask

    function automatic logic keptFunct(logic [fieldWidth-1:0] f);
        return f inside {functAdd, functSub, functAnd, functSll, functSrl,
                         functSra, functSllv, functSrav, functJr};
    endfunction

    task automatic encodeClass(opClass_t cls);
        logic [31:0] r;
        r = nextRandom();
        opcode = opcodeRType;
        case (cls)
            opAdd:  funct = functAdd;
            opSub:  funct = functSub;
            opAnd:  funct = functAnd;
            opSll:  funct = functSll;
            opSrl:  funct = functSrl;
            opSra:  funct = functSra;
            opSllv: funct = functSllv;
            opSrav: funct = functSrav;
            opJr:   funct = functJr;
            opAddi: begin
                opcode = opcodeAddi;
                funct  = r[29:24];
            end
            default: begin
                // either a free funct under R-type or a free opcode
                if (r[31]) begin
                    funct = r[29:24];
                    if (keptFunct(funct))
                        funct = 6'b111111;
                end else begin
                    opcode = r[29:24];
                    funct  = r[21:16];
                    if (opcode == opcodeRType || opcode == opcodeAddi)
                        opcode = 6'b111111;
                end
            end
        endcase
    endtask

    task automatic runInstruction(opClass_t cls, logic ovf);
        waitForFetch();
        encodeClass(cls);
        overflow = ovf;
        curClass = cls;
    endtask

    task automatic randomInstruction();
        logic [31:0] r;
        opClass_t    cls;
        r = nextRandom();
        if (r[31:16] % 10 == 0)
            cls = opUnknown;
        else
            cls = opClass_t'(4'(r[15:8] % 10));
        runInstruction(cls, r[25:24] == 2'b00);
    endtask

    initial begin
        reset    = 1'b1;
        opcode   = opcodeRType;
        funct    = functAdd;
        overflow = 1'b0;
        repeat (8) runCycle();
        reset = 1'b0;

        // every class once without and once with overflow
        testName = "directed";
        for (int i = 0; i < 11; i++) begin
            for (int v = 0; v < 2; v++)
                runInstruction(directedList[i], v == 1);
        end

        testName = "random";
        repeat (400) randomInstruction();
        waitForFetch();

        $display(">>> PASS");
        $finish;
    end

endmodule
